// ==== verilog/video_pkg.sv ====
package video_pkg;

    typedef logic [10:0] hcount_t;          // horizontal pixel counter
    typedef logic [9:0]  vcount_t;          // vertical line counter
    typedef logic [7:0]  color_t;           // palette index
    typedef logic [15:0] vaddr_t;           // vram word address
    typedef logic [15:0] word_t;            // vram and register data

    typedef struct packed {
        logic       hsync;                  // active high
        logic       vsync;                  // active high
        logic       h_blank;                // outside visible pixels
        logic       v_blank;                // outside visible lines
    } vid_sync_t;

    // visible area starts at count 0, then front porch, sync and back porch
    typedef struct packed {
        hcount_t    h_visible;
        hcount_t    h_front;
        hcount_t    h_sync;
        hcount_t    h_back;
        vcount_t    v_visible;
        vcount_t    v_front;
        vcount_t    v_sync;
        vcount_t    v_back;
    } vid_geom_t;

    localparam vid_geom_t DEFAULT_GEOM = '{
        h_visible: 11'd640,
        h_front:   11'd16,
        h_sync:    11'd96,
        h_back:    11'd48,
        v_visible: 10'd480,
        v_front:   10'd10,
        v_sync:    10'd2,
        v_back:    10'd33
    };

endpackage

// ==== verilog/xr_pkg.sv ====
package xr_pkg;

    // register number, byte address on the bus is number * 4
    typedef enum logic [3:0] {
        XR_VID_CTRL     = 4'h0,
        XR_VID_LEFT     = 4'h1,
        XR_VID_RIGHT    = 4'h2,
        XR_VID_HSIZE    = 4'h3,             // read only
        XR_VID_VSIZE    = 4'h4,             // read only
        XR_PA_GFX_CTRL  = 4'h8,
        XR_PA_DISP_ADDR = 4'h9,
        XR_PA_LINE_LEN  = 4'hA
    } xr_reg_e;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef struct packed {
        video_pkg::color_t  border;         // color outside the window
        logic [6:0]         rsvd;
        logic               intr_en;        // vertical interrupt enable
    } vid_ctrl_t;

    typedef struct packed {
        video_pkg::color_t  colorbase;      // xor into every pixel index
        logic               blank;          // show border only
        logic [6:0]         rsvd;
    } gfx_ctrl_t;

    // one register word, meaning depends on the register number
    typedef union packed {
        video_pkg::word_t   raw;
        vid_ctrl_t          vid_ctrl;
        gfx_ctrl_t          gfx_ctrl;
    } xr_word_u;

    typedef struct packed {
        logic               blank;
        video_pkg::color_t  colorbase;
        video_pkg::color_t  border;
        video_pkg::hcount_t left;           // first windowed pixel
        video_pkg::hcount_t right;          // first pixel past the window
        video_pkg::vaddr_t  start_addr;     // line 0 address
        video_pkg::word_t   line_len;       // words per line
    } pf_cfg_t;

    typedef struct packed {
        logic               awvalid;
        logic [7:0]         awaddr;
        logic               wvalid;
        logic [31:0]        wdata;
        logic [3:0]         wstrb;
        logic               bready;
        logic               arvalid;
        logic [7:0]         araddr;
        logic               rready;
    } axil_req_t;

    typedef struct packed {
        logic               awready;
        logic               wready;
        logic               bvalid;
        logic [1:0]         bresp;
        logic               arready;
        logic               rvalid;
        logic [31:0]        rdata;
        logic [1:0]         rresp;
    } axil_rsp_t;

endpackage

// ==== verilog/video_timing.sv ====
`timescale 1ns/10ps

module video_timing #(
    parameter video_pkg::vid_geom_t GEOM = video_pkg::DEFAULT_GEOM
) (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    output      video_pkg::hcount_t     h_count_o,
    output      video_pkg::vcount_t     v_count_o,
    output      video_pkg::vid_sync_t   sync_o,
    output      logic                   end_of_line_o,      // last pixel of each line
    output      logic                   end_of_frame_o,     // last pixel of the frame
    output      logic                   end_of_visible_o    // last visible pixel of the frame
);
    import video_pkg::*;

    localparam hcount_t H_SYNC_BEGIN = GEOM.h_visible + GEOM.h_front;
    localparam hcount_t H_SYNC_END   = H_SYNC_BEGIN + GEOM.h_sync;
    localparam hcount_t H_LAST       = H_SYNC_END + GEOM.h_back - 1'b1;
    localparam vcount_t V_SYNC_BEGIN = GEOM.v_visible + GEOM.v_front;
    localparam vcount_t V_SYNC_END   = V_SYNC_BEGIN + GEOM.v_sync;
    localparam vcount_t V_LAST       = V_SYNC_END + GEOM.v_back - 1'b1;
    localparam vcount_t V_VIS_LAST   = GEOM.v_visible - 1'b1;

    hcount_t    h_next;
    vcount_t    v_next;
    logic       h_wrap;

    always_comb begin
        h_wrap = (h_count_o == H_LAST);
        h_next = h_wrap ? '0 : h_count_o + 1'b1;
        v_next = v_count_o;
        if (h_wrap) begin
            v_next = (v_count_o == V_LAST) ? '0 : v_count_o + 1'b1;
        end
    end

    // everything is derived from the next count so the outputs stay aligned
    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count_o        <= '0;
            v_count_o        <= '0;
            sync_o           <= '0;                 // sync inactive, top left visible
            end_of_line_o    <= 1'b0;
            end_of_frame_o   <= 1'b0;
            end_of_visible_o <= 1'b0;
        end else begin
            h_count_o        <= h_next;
            v_count_o        <= v_next;

            sync_o.h_blank   <= (h_next >= GEOM.h_visible);
            sync_o.hsync     <= (h_next >= H_SYNC_BEGIN) && (h_next < H_SYNC_END);
            sync_o.v_blank   <= (v_next >= GEOM.v_visible);
            sync_o.vsync     <= (v_next >= V_SYNC_BEGIN) && (v_next < V_SYNC_END);

            end_of_line_o    <= (h_next == H_LAST);
            end_of_frame_o   <= (h_next == H_LAST) && (v_next == V_LAST);
            end_of_visible_o <= (h_next == H_LAST) && (v_next == V_VIS_LAST);
        end
    end

endmodule

// ==== verilog/xr_regs.sv ====
`timescale 1ns/10ps

module xr_regs #(
    parameter video_pkg::vid_geom_t GEOM = video_pkg::DEFAULT_GEOM
) (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire xr_pkg::axil_req_t      axil_i,
    input  wire logic                   end_of_visible_i,
    output      xr_pkg::axil_rsp_t      axil_o,
    output      xr_pkg::pf_cfg_t        cfg_o,
    output      logic                   intr_o          // one pulse per frame
);
    import video_pkg::*;
    import xr_pkg::*;

    localparam word_t HSIZE = word_t'(GEOM.h_visible);
    localparam word_t VSIZE = word_t'(GEOM.v_visible);

    logic       intr_en;
    logic       bvalid;
    logic       rvalid;
    word_t      rdata;
    logic       wr_go;                      // write address and data taken
    logic       rd_go;                      // read address taken
    logic       wr_mapped;
    logic       rd_mapped;
    xr_reg_e    wr_reg;
    xr_reg_e    rd_reg;
    xr_word_u   wr_word;
    xr_word_u   rd_word;

    always_comb begin
        wr_go       = axil_i.awvalid & axil_i.wvalid & ~bvalid;
        rd_go       = axil_i.arvalid & ~rvalid;
        wr_mapped   = (axil_i.awaddr[7:6] == 2'b00);
        rd_mapped   = (axil_i.araddr[7:6] == 2'b00);
        wr_reg      = xr_reg_e'(axil_i.awaddr[5:2]);
        rd_reg      = xr_reg_e'(axil_i.araddr[5:2]);
        wr_word.raw = axil_i.wdata[15:0];
    end

    // register file, the new value is visible the cycle after the write
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_o.blank      <= 1'b1;               // playfield starts blanked
            cfg_o.colorbase  <= 8'h00;
            cfg_o.border     <= 8'h08;              // dark grey
            cfg_o.left       <= '0;
            cfg_o.right      <= GEOM.h_visible;
            cfg_o.start_addr <= '0;
            cfg_o.line_len   <= word_t'(GEOM.h_visible >> 1);
            intr_en          <= 1'b0;
        end else if (wr_go && wr_mapped) begin
            case (wr_reg)
                XR_VID_CTRL: begin
                    cfg_o.border <= wr_word.vid_ctrl.border;
                    intr_en      <= wr_word.vid_ctrl.intr_en;
                end
                XR_VID_LEFT: begin
                    cfg_o.left <= wr_word.raw[$bits(hcount_t)-1:0];
                end
                XR_VID_RIGHT: begin
                    cfg_o.right <= wr_word.raw[$bits(hcount_t)-1:0];
                end
                XR_PA_GFX_CTRL: begin
                    cfg_o.colorbase <= wr_word.gfx_ctrl.colorbase;
                    cfg_o.blank     <= wr_word.gfx_ctrl.blank;
                end
                XR_PA_DISP_ADDR: begin
                    cfg_o.start_addr <= wr_word.raw;
                end
                XR_PA_LINE_LEN: begin
                    cfg_o.line_len <= wr_word.raw;
                end
                default: begin                      // hsize/vsize and holes
                end
            endcase
        end
    end

    always_comb begin
        rd_word.raw = '0;                           // undefined bits read 0
        if (rd_mapped) begin
            case (rd_reg)
                XR_VID_CTRL: begin
                    rd_word.vid_ctrl.border  = cfg_o.border;
                    rd_word.vid_ctrl.intr_en = intr_en;
                end
                XR_VID_LEFT:     rd_word.raw = word_t'(cfg_o.left);
                XR_VID_RIGHT:    rd_word.raw = word_t'(cfg_o.right);
                XR_VID_HSIZE:    rd_word.raw = HSIZE;
                XR_VID_VSIZE:    rd_word.raw = VSIZE;
                XR_PA_GFX_CTRL: begin
                    rd_word.gfx_ctrl.colorbase = cfg_o.colorbase;
                    rd_word.gfx_ctrl.blank     = cfg_o.blank;
                end
                XR_PA_DISP_ADDR: rd_word.raw = cfg_o.start_addr;
                XR_PA_LINE_LEN:  rd_word.raw = cfg_o.line_len;
                default:         rd_word.raw = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            rdata <= rd_word.raw;                   // held until the next read
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            intr_o <= 1'b0;
        end else begin
            if (wr_go) begin
                bvalid <= 1'b1;
            end else if (axil_i.bready) begin
                bvalid <= 1'b0;
            end
            if (rd_go) begin
                rvalid <= 1'b1;
            end else if (axil_i.rready) begin
                rvalid <= 1'b0;
            end
            intr_o <= end_of_visible_i & intr_en;  // vertical blank start
        end
    end

    always_comb begin
        axil_o         = '0;
        axil_o.awready = wr_go;
        axil_o.wready  = wr_go;
        axil_o.bvalid  = bvalid;
        axil_o.bresp   = AXI_RESP_OKAY;
        axil_o.arready = rd_go;
        axil_o.rvalid  = rvalid;
        axil_o.rdata   = {16'h0000, rdata};
        axil_o.rresp   = AXI_RESP_OKAY;
    end

endmodule

// ==== verilog/bitmap_fetch.sv ====
`timescale 1ns/10ps

module bitmap_fetch #(
    parameter video_pkg::vid_geom_t GEOM = video_pkg::DEFAULT_GEOM
) (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire xr_pkg::pf_cfg_t        cfg_i,
    input  wire video_pkg::hcount_t     h_count_i,
    input  wire video_pkg::vcount_t     v_count_i,
    input  wire video_pkg::vid_sync_t   sync_i,
    input  wire logic                   end_of_line_i,
    input  wire logic                   end_of_frame_i,
    input  wire video_pkg::word_t       vram_data_i,    // valid one cycle after select
    output      logic                   vram_sel_o,
    output      video_pkg::vaddr_t      vram_addr_o,
    output      video_pkg::color_t      color_o,
    output      video_pkg::vid_sync_t   sync_o          // sync aligned with color_o
);
    import video_pkg::*;
    import xr_pkg::*;

    localparam int PIX_DELAY = 4;                       // counters to color_o
    localparam int PIPE_LEN  = PIX_DELAY - 1;           // last stage feeds the output reg

    typedef struct packed {
        vid_sync_t  sync;
        logic       odd;                                // low byte of the word
        logic       show;                               // bitmap pixel, else border
    } pix_tag_t;

    pix_tag_t                   tag_in;
    pix_tag_t                   tag_out;
    pix_tag_t [PIPE_LEN-1:0]    tag_pipe;
    vaddr_t                     line_addr;              // word address of the current line
    logic                       fetch;
    logic                       vram_rd;                // data arrives this cycle
    word_t                      pix_word;
    color_t                     pix_byte;

    // one word per pixel pair, fetched on the even pixel
    always_comb begin
        fetch       = ~cfg_i.blank & ~sync_i.h_blank & ~sync_i.v_blank & ~h_count_i[0];
        tag_in.sync = sync_i;
        tag_in.odd  = h_count_i[0];
        tag_in.show = ~cfg_i.blank && (h_count_i >= cfg_i.left) && (h_count_i < cfg_i.right);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_addr <= '0;
        end else if (end_of_frame_i) begin
            line_addr <= cfg_i.start_addr;              // new frame
        end else if (end_of_line_i && (v_count_i < GEOM.v_visible)) begin
            line_addr <= line_addr + cfg_i.line_len;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o <= 1'b0;
            vram_rd    <= 1'b0;
            tag_pipe   <= '0;
        end else begin
            vram_sel_o <= fetch;
            vram_rd    <= vram_sel_o;
            tag_pipe   <= {tag_pipe[PIPE_LEN-2:0], tag_in};
        end
    end

    always_ff @(posedge clk) begin
        vram_addr_o <= line_addr + vaddr_t'(h_count_i[$bits(hcount_t)-1:1]);
        if (vram_rd) begin
            pix_word <= vram_data_i;                    // kept for both pixels
        end
    end

    assign tag_out  = tag_pipe[PIPE_LEN-1];
    assign pix_byte = tag_out.odd ? pix_word[7:0] : pix_word[15:8];  // high byte first

    always_ff @(posedge clk) begin
        if (reset_i) begin
            color_o <= '0;
            sync_o  <= '0;
        end else begin
            sync_o <= tag_out.sync;
            if (tag_out.sync.h_blank || tag_out.sync.v_blank) begin
                color_o <= '0;
            end else if (tag_out.show) begin
                color_o <= pix_byte ^ cfg_i.colorbase;
            end else begin
                color_o <= cfg_i.border;
            end
        end
    end

endmodule

// ==== verilog/video_gen.sv ====
`timescale 1ns/10ps

module video_gen #(
    parameter video_pkg::vid_geom_t GEOM = video_pkg::DEFAULT_GEOM
) (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire xr_pkg::axil_req_t      axil_i,         // cpu register bus
    output      xr_pkg::axil_rsp_t      axil_o,
    output      logic                   intr_o,         // vertical interrupt
    output      logic                   vram_sel_o,
    output      video_pkg::vaddr_t      vram_addr_o,
    input  wire video_pkg::word_t       vram_data_i,
    output      video_pkg::color_t      color_o,        // palette index
    output      logic                   hsync_o,
    output      logic                   vsync_o,
    output      logic                   h_blank_o,
    output      logic                   v_blank_o
);
    import video_pkg::*;
    import xr_pkg::*;

    hcount_t    h_count;
    vcount_t    v_count;
    vid_sync_t  tim_sync;                               // at counter time
    vid_sync_t  pix_sync;                               // at pixel output time
    logic       end_of_line;
    logic       end_of_frame;
    logic       end_of_visible;
    pf_cfg_t    pf_cfg;

    video_timing #(
        .GEOM(GEOM)
    ) i_video_timing (
        .clk(clk),
        .reset_i(reset_i),
        .h_count_o(h_count),
        .v_count_o(v_count),
        .sync_o(tim_sync),
        .end_of_line_o(end_of_line),
        .end_of_frame_o(end_of_frame),
        .end_of_visible_o(end_of_visible)
    );

    xr_regs #(
        .GEOM(GEOM)
    ) i_xr_regs (
        .clk(clk),
        .reset_i(reset_i),
        .axil_i(axil_i),
        .end_of_visible_i(end_of_visible),
        .axil_o(axil_o),
        .cfg_o(pf_cfg),
        .intr_o(intr_o)
    );

    bitmap_fetch #(
        .GEOM(GEOM)
    ) i_bitmap_fetch (
        .clk(clk),
        .reset_i(reset_i),
        .cfg_i(pf_cfg),
        .h_count_i(h_count),
        .v_count_i(v_count),
        .sync_i(tim_sync),
        .end_of_line_i(end_of_line),
        .end_of_frame_i(end_of_frame),
        .vram_data_i(vram_data_i),
        .vram_sel_o(vram_sel_o),
        .vram_addr_o(vram_addr_o),
        .color_o(color_o),
        .sync_o(pix_sync)
    );

    assign hsync_o   = pix_sync.hsync;
    assign vsync_o   = pix_sync.vsync;
    assign h_blank_o = pix_sync.h_blank;
    assign v_blank_o = pix_sync.v_blank;

endmodule

// ==== verif/video_gen_tb.sv ====
`timescale 1ns/10ps

module video_gen_tb;
    import video_pkg::*;
    import xr_pkg::*;

    localparam int H_VIS        = 32;
    localparam int V_VIS        = 6;
    localparam int H_TOTAL      = 32 + 4 + 4 + 8;
    localparam int V_TOTAL      = 6 + 1 + 1 + 2;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int TIMEOUT      = 2 * FRAME_CYCLES;

    localparam logic [1:0] CHK_NONE   = 2'd0;
    localparam logic [1:0] CHK_PIXELS = 2'd1;     // walk one frame of pixels
    localparam logic [1:0] CHK_SYNC   = 2'd2;     // count sync and irq over three frames

    localparam vid_geom_t TB_GEOM = '{
        h_visible: 11'd32,
        h_front:   11'd4,
        h_sync:    11'd4,
        h_back:    11'd8,
        v_visible: 10'd6,
        v_front:   10'd1,
        v_sync:    10'd1,
        v_back:    10'd2
    };

    typedef struct packed {
        logic           wr;                     // write before the readback
        logic [7:0]     addr;                   // axi byte address
        logic [15:0]    wdata;
        logic [15:0]    rd_exp;
        logic [1:0]     chk;
    } row_t;

    logic           clk = 1'b0;
    logic           reset_i;
    axil_req_t      axil_i;
    axil_rsp_t      axil_o;
    logic           intr_o;
    logic           vram_sel_o;
    vaddr_t         vram_addr_o;
    word_t          vram_data_i;
    color_t         color_o;
    logic           hsync_o;
    logic           vsync_o;
    logic           h_blank_o;
    logic           v_blank_o;

    word_t          vram [256];
    logic           vram_pend;                  // read issued last cycle
    vaddr_t         vram_pend_addr;
    logic [31:0]    lcg_state;
    row_t           rows [$];

    color_t         m_border;                   // expected register state
    logic           m_intr_en;
    int             m_left;
    int             m_right;
    color_t         m_colorbase;
    logic           m_blank;
    vaddr_t         m_start;
    word_t          m_line_len;

    video_gen #(
        .GEOM(TB_GEOM)
    ) i_video_gen (
        .clk(clk),
        .reset_i(reset_i),
        .axil_i(axil_i),
        .axil_o(axil_o),
        .intr_o(intr_o),
        .vram_sel_o(vram_sel_o),
        .vram_addr_o(vram_addr_o),
        .vram_data_i(vram_data_i),
        .color_o(color_o),
        .hsync_o(hsync_o),
        .vsync_o(vsync_o),
        .h_blank_o(h_blank_o),
        .v_blank_o(v_blank_o)
    );

    always #5 clk = ~clk;

    // data presented on the falling edge one cycle after the select
    always @(negedge clk) begin
        if (vram_pend) begin
            vram_data_i = vram[vram_pend_addr[7:0]];
        end
        vram_pend      = vram_sel_o;
        vram_pend_addr = vram_addr_o;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [7:0] reg_addr(input xr_reg_e r);
        return {2'b00, r, 2'b00};
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic add_row(input logic wr, input logic [7:0] addr, input logic [15:0] wdata,
                           input logic [15:0] rd_exp, input logic [1:0] chk);
        row_t r;
        r.wr     = wr;
        r.addr   = addr;
        r.wdata  = wdata;
        r.rd_exp = rd_exp;
        r.chk    = chk;
        rows.push_back(r);
    endtask

    task automatic model_reset();
        m_border    = 8'h08;
        m_intr_en   = 1'b0;
        m_left      = 0;
        m_right     = H_VIS;
        m_colorbase = 8'h00;
        m_blank     = 1'b1;
        m_start     = 16'h0000;
        m_line_len  = 16'(H_VIS / 2);
    endtask

    // holes and read only registers change nothing
    task automatic model_write(input logic [7:0] addr, input logic [15:0] data);
        if (addr[7:6] == 2'b00) begin
            case (addr[5:2])
                4'h0: begin
                    m_border  = data[15:8];
                    m_intr_en = data[0];
                end
                4'h1: m_left = int'(data[10:0]);
                4'h2: m_right = int'(data[10:0]);
                4'h8: begin
                    m_colorbase = data[15:8];
                    m_blank     = data[7];
                end
                4'h9: m_start = data;
                4'hA: m_line_len = data;
                default: begin
                end
            endcase
        end
    endtask

    function automatic color_t expected_pixel(input int x, input int y);
        vaddr_t a;
        word_t  w;
        if (m_blank || x < m_left || x >= m_right) begin
            return m_border;
        end
        a = m_start + vaddr_t'(y) * m_line_len + vaddr_t'(x / 2);
        w = vram[a[7:0]];
        return ((x % 2 == 0) ? w[15:8] : w[7:0]) ^ m_colorbase;    // high byte first
    endfunction

    task automatic axi_write(input logic [7:0] addr, input logic [15:0] data);
        int          n;
        int          i;
        int          hold;
        logic [31:0] rnd;
        axil_i.awvalid = 1'b1;
        axil_i.awaddr  = addr;
        axil_i.wvalid  = 1'b1;
        axil_i.wdata   = {16'h0000, data};
        axil_i.wstrb   = 4'hf;
        n = 0;
        @(negedge clk);
        while (!axil_o.bvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (axil_o.bvalid) else abort_run("write response never arrived");
        check_value("awready", 32'(axil_o.awready), 32'd0);     // no second accept
        check_value("bresp", 32'(axil_o.bresp), 32'd0);
        axil_i.awvalid = 1'b0;
        axil_i.wvalid  = 1'b0;
        rnd  = lcg_next();
        hold = int'(rnd[31:29]);
        for (i = 0; i < hold; i++) begin
            @(negedge clk);
            check_value("bvalid", 32'(axil_o.bvalid), 32'd1);
        end
        axil_i.bready = 1'b1;
        @(negedge clk);
        check_value("bvalid", 32'(axil_o.bvalid), 32'd0);
        axil_i.bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
        int          n;
        int          i;
        int          hold;
        logic [31:0] rnd;
        axil_i.arvalid = 1'b1;
        axil_i.araddr  = addr;
        n = 0;
        @(negedge clk);
        while (!axil_o.rvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (axil_o.rvalid) else abort_run("read data never arrived");
        axil_i.arvalid = 1'b0;
        // another address on the idle bus must not reach the held rdata
        axil_i.araddr  = (addr == reg_addr(XR_VID_HSIZE)) ? reg_addr(XR_VID_VSIZE)
                                                          : reg_addr(XR_VID_HSIZE);
        data = axil_o.rdata;
        check_value("rresp", 32'(axil_o.rresp), 32'd0);
        rnd  = lcg_next();
        hold = int'(rnd[31:29]);
        for (i = 0; i < hold; i++) begin
            @(negedge clk);
            check_value("rvalid", 32'(axil_o.rvalid), 32'd1);
            check_value("rdata", axil_o.rdata, data);        // stable under back-pressure
        end
        axil_i.rready = 1'b1;
        @(negedge clk);
        check_value("rvalid", 32'(axil_o.rvalid), 32'd0);
        axil_i.rready = 1'b0;
    endtask

    task automatic wait_vsync_rise();
        int n;
        n = 0;
        while (vsync_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (!vsync_o) else abort_run("vsync_o stuck high");
        n = 0;
        while (!vsync_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (vsync_o) else abort_run("no vsync_o pulse seen");
    endtask

    task automatic check_frame();
        int n;
        int x;
        int y;
        wait_vsync_rise();                      // start address is latched before the next frame
        n = 0;
        while ((h_blank_o || v_blank_o) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (!h_blank_o && !v_blank_o) else abort_run("no visible pixel after vsync");
        x = 0;
        y = 0;
        for (n = 0; n < FRAME_CYCLES; n++) begin
            if (!h_blank_o && !v_blank_o) begin
                check_value($sformatf("color_o(%0d,%0d)", x, y), 32'(color_o),
                            32'(expected_pixel(x, y)));
                x++;
            end else begin
                check_value("color_o in blanking", 32'(color_o), 32'd0);
                if (x != 0) begin
                    check_value("pixels per line", 32'(x), 32'(H_VIS));
                    x = 0;
                    y++;
                end
            end
            @(negedge clk);
        end
        check_value("lines per frame", 32'(y), 32'(V_VIS));
    endtask

    task automatic check_sync_intr(input int exp_intr);
        int   n;
        int   h_rise;
        int   v_rise;
        int   i_rise;
        int   i_high;
        logic h_prev;
        logic v_prev;
        logic i_prev;
        wait_vsync_rise();
        h_prev = hsync_o;
        v_prev = vsync_o;
        i_prev = intr_o;
        h_rise = 0;
        v_rise = 0;
        i_rise = 0;
        i_high = 0;
        for (n = 0; n < 3 * FRAME_CYCLES; n++) begin
            @(negedge clk);
            if (hsync_o && !h_prev) h_rise++;
            if (vsync_o && !v_prev) v_rise++;
            if (intr_o && !i_prev) i_rise++;
            if (intr_o) i_high++;
            h_prev = hsync_o;
            v_prev = vsync_o;
            i_prev = intr_o;
        end
        check_value("hsync_o pulses", 32'(h_rise), 32'(3 * V_TOTAL));
        check_value("vsync_o pulses", 32'(v_rise), 32'd3);
        check_value("intr_o pulses", 32'(i_rise), 32'(exp_intr));
        check_value("intr_o high cycles", 32'(i_high), 32'(exp_intr));  // one cycle each
    endtask

    task automatic build_table();
        add_row(1'b0, reg_addr(XR_VID_CTRL), 16'h0000, 16'h0800, CHK_NONE);    // reset values
        add_row(1'b0, reg_addr(XR_VID_LEFT), 16'h0000, 16'h0000, CHK_NONE);
        add_row(1'b0, reg_addr(XR_VID_RIGHT), 16'h0000, 16'h0020, CHK_NONE);
        add_row(1'b0, reg_addr(XR_VID_HSIZE), 16'h0000, 16'h0020, CHK_NONE);
        add_row(1'b0, reg_addr(XR_VID_VSIZE), 16'h0000, 16'h0006, CHK_NONE);
        add_row(1'b0, reg_addr(XR_PA_GFX_CTRL), 16'h0000, 16'h0080, CHK_NONE);
        add_row(1'b0, reg_addr(XR_PA_DISP_ADDR), 16'h0000, 16'h0000, CHK_NONE);
        add_row(1'b0, reg_addr(XR_PA_LINE_LEN), 16'h0000, 16'h0010, CHK_PIXELS);
        add_row(1'b1, reg_addr(XR_VID_CTRL), 16'h5a81, 16'h5a01, CHK_NONE);
        add_row(1'b1, reg_addr(XR_PA_GFX_CTRL), 16'h33ff, 16'h3380, CHK_PIXELS);
        add_row(1'b1, reg_addr(XR_VID_LEFT), 16'hffff, 16'h07ff, CHK_NONE);
        add_row(1'b1, reg_addr(XR_VID_RIGHT), 16'hf805, 16'h0005, CHK_NONE);
        add_row(1'b1, reg_addr(XR_VID_HSIZE), 16'h1234, 16'h0020, CHK_NONE);   // read only
        add_row(1'b1, reg_addr(XR_VID_VSIZE), 16'hbeef, 16'h0006, CHK_NONE);
        add_row(1'b1, 8'h14, 16'hffff, 16'h0000, CHK_NONE);                    // holes
        add_row(1'b1, 8'h2c, 16'hffff, 16'h0000, CHK_NONE);
        add_row(1'b1, 8'h40, 16'h0000, 16'h0000, CHK_NONE);
        add_row(1'b0, reg_addr(XR_VID_CTRL), 16'h0000, 16'h5a01, CHK_NONE);
        add_row(1'b1, reg_addr(XR_PA_DISP_ADDR), 16'habcd, 16'habcd, CHK_NONE);
        add_row(1'b1, reg_addr(XR_PA_LINE_LEN), 16'h8001, 16'h8001, CHK_NONE);
        add_row(1'b1, reg_addr(XR_VID_LEFT), 16'h0000, 16'h0000, CHK_NONE);
        add_row(1'b1, reg_addr(XR_VID_RIGHT), 16'h0020, 16'h0020, CHK_NONE);
        add_row(1'b1, reg_addr(XR_PA_DISP_ADDR), 16'h0000, 16'h0000, CHK_NONE);
        add_row(1'b1, reg_addr(XR_PA_LINE_LEN), 16'h0010, 16'h0010, CHK_NONE);
        add_row(1'b1, reg_addr(XR_PA_GFX_CTRL), 16'h0000, 16'h0000, CHK_PIXELS);
        add_row(1'b1, reg_addr(XR_PA_DISP_ADDR), 16'h0137, 16'h0137, CHK_NONE);
        add_row(1'b1, reg_addr(XR_PA_LINE_LEN), 16'h0013, 16'h0013, CHK_NONE);
        add_row(1'b1, reg_addr(XR_VID_LEFT), 16'h0003, 16'h0003, CHK_NONE);
        add_row(1'b1, reg_addr(XR_VID_RIGHT), 16'h001b, 16'h001b, CHK_NONE);
        add_row(1'b1, reg_addr(XR_PA_GFX_CTRL), 16'ha57f, 16'ha500, CHK_PIXELS);
        add_row(1'b1, reg_addr(XR_VID_CTRL), 16'h3c00, 16'h3c00, CHK_NONE);
        add_row(1'b1, reg_addr(XR_PA_DISP_ADDR), 16'hfff0, 16'hfff0, CHK_NONE);
        add_row(1'b1, reg_addr(XR_PA_LINE_LEN), 16'hfffd, 16'hfffd, CHK_NONE);  // negative stride
        add_row(1'b1, reg_addr(XR_VID_LEFT), 16'h000a, 16'h000a, CHK_NONE);
        add_row(1'b1, reg_addr(XR_VID_RIGHT), 16'h0007, 16'h0007, CHK_NONE);   // empty window
        add_row(1'b1, reg_addr(XR_PA_GFX_CTRL), 16'h0f00, 16'h0f00, CHK_PIXELS);
        add_row(1'b1, reg_addr(XR_VID_RIGHT), 16'h0040, 16'h0040, CHK_PIXELS);
        add_row(1'b1, reg_addr(XR_VID_CTRL), 16'h3c00, 16'h3c00, CHK_SYNC);
        add_row(1'b1, reg_addr(XR_VID_CTRL), 16'h3c01, 16'h3c01, CHK_SYNC);
    endtask

    initial begin
        int          i;
        row_t        r;
        logic [31:0] got;
        reset_i        = 1'b1;
        axil_i         = '0;
        vram_data_i    = '0;
        vram_pend      = 1'b0;
        vram_pend_addr = '0;
        lcg_state      = 32'hff45;
        for (i = 0; i < 256; i++) begin
            got     = lcg_next();
            vram[i] = got[31:16];
        end
        model_reset();
        build_table();

        repeat (16) @(negedge clk);
        check_value("hsync_o", 32'(hsync_o), 32'd0);
        check_value("vsync_o", 32'(vsync_o), 32'd0);
        check_value("color_o", 32'(color_o), 32'd0);
        check_value("vram_sel_o", 32'(vram_sel_o), 32'd0);
        reset_i = 1'b0;
        @(negedge clk);
        check_value("awready", 32'(axil_o.awready), 32'd0);
        check_value("wready", 32'(axil_o.wready), 32'd0);
        check_value("bvalid", 32'(axil_o.bvalid), 32'd0);
        check_value("arready", 32'(axil_o.arready), 32'd0);
        check_value("rvalid", 32'(axil_o.rvalid), 32'd0);
        check_value("intr_o", 32'(intr_o), 32'd0);

        for (i = 0; i < rows.size(); i++) begin
            r = rows[i];
            if (r.wr) begin
                axi_write(r.addr, r.wdata);
                model_write(r.addr, r.wdata);
            end
            axi_read(r.addr, got);
            check_value($sformatf("rdata[%02h]", r.addr), got, {16'h0000, r.rd_exp});
            if (r.chk == CHK_PIXELS) begin
                check_frame();
            end else if (r.chk == CHK_SYNC) begin
                check_sync_intr(m_intr_en ? 3 : 0);
            end
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== filelist.f ====
verilog/video_pkg.sv
verilog/xr_pkg.sv
verilog/video_timing.sv
verilog/xr_regs.sv
verilog/bitmap_fetch.sv
verilog/video_gen.sv
verif/video_gen_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the video generator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/10ps -j 0 \
    --top-module video_gen_tb -f filelist.f

out=$(./obj_dir/Vvideo_gen_tb 2>&1) || true
echo "$out"
echo "$out" | grep -q "All tests passed"
